/* source/rv_decode_pkg.sv */
/*
 * Shared encodings and types of the registered RISC-V decoder.
 * Holds the canonical RV32I opcode and funct3 values, the datapath select
 * codes, the stage structs and the latency constants. Every file refers to
 * these by scoped names.
 */
`default_nettype none

package rv_decode_pkg;

	////////////////////
	// widths, latency
	////////////////////
	localparam int INST_W         = 32;
	localparam int EXPAND_LATENCY = 1;  // rvc_expander register
	localparam int PIPE_STAGES    = 2;  // default decode_pipe depth
	localparam int CTRL_LATENCY   = 1;  // ctrl_generator register
	localparam int DECODE_LATENCY = EXPAND_LATENCY + PIPE_STAGES + CTRL_LATENCY;

	////////////////////
	// opcodes
	////////////////////
	// inst[6:2], the low two bits are always 11 after expansion
	typedef enum logic [4:0] {
		OPC_LOAD   = 5'b00000,
		OPC_OP_IMM = 5'b00100,
		OPC_AUIPC  = 5'b00101,
		OPC_STORE  = 5'b01000,
		OPC_OP     = 5'b01100,
		OPC_LUI    = 5'b01101,
		OPC_BRANCH = 5'b11000,
		OPC_JALR   = 5'b11001,
		OPC_JAL    = 5'b11011
	} opcode_e;

	// integer ops, shared by OP and OP_IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	// loads
	localparam logic [2:0] F3_LB      = 3'b000;
	localparam logic [2:0] F3_LH      = 3'b001;
	localparam logic [2:0] F3_LW      = 3'b010;
	localparam logic [2:0] F3_LBU     = 3'b100;
	localparam logic [2:0] F3_LHU     = 3'b101;
	// stores
	localparam logic [2:0] F3_SB      = 3'b000;
	localparam logic [2:0] F3_SH      = 3'b001;
	localparam logic [2:0] F3_SW      = 3'b010;
	// branches, only the ones rvc produces
	localparam logic [2:0] F3_BEQ     = 3'b000;
	localparam logic [2:0] F3_BNE     = 3'b001;

	////////////////////
	// datapath selects
	////////////////////
	typedef enum logic [1:0] {A_SEL_RS1, A_SEL_PC, A_SEL_ZERO} a_sel_e;
	typedef enum logic [1:0] {B_SEL_RS2, B_SEL_IMM} b_sel_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef enum logic [1:0] {L8, L16, L32} mem_len_e;
	typedef enum logic [2:0] {WB_ALU, WB_LOAD, WB_PC4} wb_src_e;

	////////////////////
	// stage structs
	////////////////////
	// expander to control stage, 11 bits
	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] funct3;
		logic       alt;         // funct7[5], sub and sra
		logic       compressed;  // came in as a 16 bit word
		logic       legal;
	} canon_inst_t;

	// control bundle to the datapath, 19 bits
	typedef struct packed {
		a_sel_e   a_sel;
		b_sel_e   b_sel;
		alu_op_e  alu_op;
		logic     mem_read;
		logic     mem_write;
		mem_len_e mem_len;
		logic     load_signed;  // 0 zero ext
		wb_src_e  wb_src;
		logic     reg_we;
		logic     illegal;
	} ctrl_bundle_t;

	// true for the nine opcodes the decoder knows
	function automatic logic is_known_opcode(logic [4:0] op);
		case (op)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
			OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/rvc_expander.sv */
/*
 * Front stage of the decoder.
 * Classifies each incoming word as RV32 or RVC, maps compressed words onto
 * the canonical RV32I opcode, funct3 and alt bit, and registers the result
 * on the input strobe. One cycle of latency.
 */
`default_nettype none

module rvc_expander (
	input  wire logic                          clk_i,
	input  wire logic                          arst_n_i,
	input  wire logic [rv_decode_pkg::INST_W-1:0] inst_i,
	input  wire logic                          inst_valid_i,
	output rv_decode_pkg::canon_inst_t         canon_o,
	output logic                               canon_valid_o
);

	logic                       is_rvc;     // low bits not 11
	logic [2:0]                 c_f3;       // rvc funct3, bits 15:13
	logic [4:0]                 c_rd;       // rd / rs1 field
	logic [4:0]                 c_rs2;      // rs2 field, quadrant 2
	rv_decode_pkg::canon_inst_t canon_nxt;
	rv_decode_pkg::canon_inst_t canon_q;
	logic                       valid_q;

	assign is_rvc = (inst_i[1:0] != 2'b11);
	assign c_f3   = inst_i[15:13];
	assign c_rd   = inst_i[11:7];
	assign c_rs2  = inst_i[6:2];

	////////////////////
	// expansion
	////////////////////
	always_comb begin : expand
		// addi with funct7 clear unless told otherwise
		canon_nxt.opcode     = rv_decode_pkg::OPC_OP_IMM;
		canon_nxt.funct3     = rv_decode_pkg::F3_ADD_SUB;
		canon_nxt.alt        = 1'b0;
		canon_nxt.compressed = is_rvc;
		canon_nxt.legal      = 1'b1;
		case (inst_i[1:0])
			2'b00: begin // quadrant 0
				case (c_f3)
					3'b000: ; // c.addi4spn -> addi rd', x2, uimm
					3'b010: begin // c.lw
						canon_nxt.opcode = rv_decode_pkg::OPC_LOAD;
						canon_nxt.funct3 = rv_decode_pkg::F3_LW;
					end
					3'b110: begin // c.sw
						canon_nxt.opcode = rv_decode_pkg::OPC_STORE;
						canon_nxt.funct3 = rv_decode_pkg::F3_SW;
					end
					default: canon_nxt.legal = 1'b0; // fp and reserved slots
				endcase
			end
			2'b01: begin // quadrant 1
				case (c_f3)
					3'b000, 3'b010: ; // c.addi, c.li -> addi
					3'b001, 3'b101: canon_nxt.opcode = rv_decode_pkg::OPC_JAL; // c.jal, c.j
					3'b011: begin
						// rd x2 is c.addi16sp, anything else c.lui
						if (c_rd != 5'd2)
							canon_nxt.opcode = rv_decode_pkg::OPC_LUI;
					end
					3'b110: begin // c.beqz
						canon_nxt.opcode = rv_decode_pkg::OPC_BRANCH;
						canon_nxt.funct3 = rv_decode_pkg::F3_BEQ;
					end
					3'b111: begin // c.bnez
						canon_nxt.opcode = rv_decode_pkg::OPC_BRANCH;
						canon_nxt.funct3 = rv_decode_pkg::F3_BNE;
					end
					default: begin // 100, alu group
						case (inst_i[11:10])
							2'b00: canon_nxt.funct3 = rv_decode_pkg::F3_SRL_SRA; // c.srli
							2'b01: begin // c.srai
								canon_nxt.funct3 = rv_decode_pkg::F3_SRL_SRA;
								canon_nxt.alt    = 1'b1;
							end
							2'b10: canon_nxt.funct3 = rv_decode_pkg::F3_AND; // c.andi
							default: begin
								// register-register forms, picked by bits 6:5
								canon_nxt.opcode = rv_decode_pkg::OPC_OP;
								case (inst_i[6:5])
									2'b00: begin // c.sub
										canon_nxt.funct3 = rv_decode_pkg::F3_ADD_SUB;
										canon_nxt.alt    = 1'b1;
									end
									2'b01:   canon_nxt.funct3 = rv_decode_pkg::F3_XOR;
									2'b10:   canon_nxt.funct3 = rv_decode_pkg::F3_OR;
									default: canon_nxt.funct3 = rv_decode_pkg::F3_AND;
								endcase
							end
						endcase
					end
				endcase
			end
			2'b10: begin // quadrant 2
				case (c_f3)
					3'b000: canon_nxt.funct3 = rv_decode_pkg::F3_SLL; // c.slli
					3'b010: begin // c.lwsp
						canon_nxt.opcode = rv_decode_pkg::OPC_LOAD;
						canon_nxt.funct3 = rv_decode_pkg::F3_LW;
					end
					3'b100: begin
						if (c_rd == 5'd0)
							canon_nxt.legal = 1'b0;  // c.ebreak, reserved jr
						else if (c_rs2 == 5'd0)
							canon_nxt.opcode = rv_decode_pkg::OPC_JALR; // c.jr, c.jalr
						else
							canon_nxt.opcode = rv_decode_pkg::OPC_OP;   // c.mv, c.add
					end
					3'b110: begin // c.swsp
						canon_nxt.opcode = rv_decode_pkg::OPC_STORE;
						canon_nxt.funct3 = rv_decode_pkg::F3_SW;
					end
					default: canon_nxt.legal = 1'b0;
				endcase
			end
			default: begin // full 32 bit word, fields as they are
				canon_nxt.opcode = rv_decode_pkg::opcode_e'(inst_i[6:2]);
				canon_nxt.funct3 = inst_i[14:12];
				canon_nxt.alt    = inst_i[30];
				canon_nxt.legal  = rv_decode_pkg::is_known_opcode(inst_i[6:2]);
			end
		endcase
	end

	////////////////////
	// stage register
	////////////////////
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= inst_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (inst_valid_i)
			canon_q <= canon_nxt;  // held between strobes
	end

	assign canon_o       = canon_q;
	assign canon_valid_o = valid_q;

	// control stage trusts legal to mean a decodable opcode
	a_legal_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(canon_valid_o && canon_o.legal) |-> rv_decode_pkg::is_known_opcode(canon_o.opcode))
		else $error("expander marked unknown opcode %b legal", canon_o.opcode);

endmodule

`default_nettype wire

/* source/decode_pipe.sv */
/*
 * Fixed delay line between expansion and control generation.
 * Each of STAGES slots captures the canonical fields when its valid input
 * is high; the valid bit simply shifts along. No back-pressure.
 */
`default_nettype none

module decode_pipe #(
	parameter int STAGES = rv_decode_pkg::PIPE_STAGES  // 1 or more
) (
	input  wire logic                       clk_i,
	input  wire logic                       arst_n_i,
	input  rv_decode_pkg::canon_inst_t      canon_i,
	input  wire logic                       canon_valid_i,
	output rv_decode_pkg::canon_inst_t      canon_o,
	output logic                            canon_valid_o
);

	rv_decode_pkg::canon_inst_t slot_in [STAGES];  // data into each slot
	rv_decode_pkg::canon_inst_t slot_q  [STAGES];
	logic [STAGES-1:0]          vld_in;
	logic [STAGES-1:0]          vld_q;

	for (genvar s = 0; s < STAGES; s++) begin : g_slot
		if (s == 0) begin : g_head
			assign slot_in[s] = canon_i;
			assign vld_in[s]  = canon_valid_i;
		end else begin : g_body
			assign slot_in[s] = slot_q[s-1];
			assign vld_in[s]  = vld_q[s-1];
		end

		always_ff @(posedge clk_i or negedge arst_n_i) begin
			if (!arst_n_i)
				vld_q[s] <= 1'b0;
			else
				vld_q[s] <= vld_in[s];
		end

		always_ff @(posedge clk_i) begin
			if (vld_in[s])
				slot_q[s] <= slot_in[s];  // capture only on a live strobe
		end
	end

	assign canon_o       = slot_q[STAGES-1];
	assign canon_valid_o = vld_q[STAGES-1];

	a_valid_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!$isunknown(canon_valid_o))
		else $error("decode_pipe output valid is unknown");

endmodule

`default_nettype wire

/* source/ctrl_generator.sv */
/*
 * Back stage of the decoder.
 * Turns canonical opcode fields into the datapath control bundle: operand
 * selects, ALU operation, memory strobes and length, write-back source and
 * register write enable. Registered, one cycle of latency.
 */
`default_nettype none

module ctrl_generator (
	input  wire logic                       clk_i,
	input  wire logic                       arst_n_i,
	input  rv_decode_pkg::canon_inst_t      canon_i,
	input  wire logic                       canon_valid_i,
	output rv_decode_pkg::ctrl_bundle_t     ctrl_o,
	output logic                            ctrl_valid_o
);

	rv_decode_pkg::alu_op_e      alu_f3;    // op picked by funct3
	logic                        is_op;     // register-register form
	rv_decode_pkg::ctrl_bundle_t ctrl_nxt;
	rv_decode_pkg::ctrl_bundle_t ctrl_q;
	logic                        valid_q;

	assign is_op = (canon_i.opcode == rv_decode_pkg::OPC_OP);

	////////////////////
	// alu select
	////////////////////
	always_comb begin : alu_decode
		case (canon_i.funct3)
			rv_decode_pkg::F3_ADD_SUB: begin
				// addi has no sub, imm bit 30 is data there
				alu_f3 = (is_op && canon_i.alt) ? rv_decode_pkg::ALU_SUB
				                                : rv_decode_pkg::ALU_ADD;
			end
			rv_decode_pkg::F3_SLL:  alu_f3 = rv_decode_pkg::ALU_SLL;
			rv_decode_pkg::F3_SLT:  alu_f3 = rv_decode_pkg::ALU_SLT;
			rv_decode_pkg::F3_SLTU: alu_f3 = rv_decode_pkg::ALU_SLTU;
			rv_decode_pkg::F3_XOR:  alu_f3 = rv_decode_pkg::ALU_XOR;
			rv_decode_pkg::F3_SRL_SRA: begin
				alu_f3 = canon_i.alt ? rv_decode_pkg::ALU_SRA
				                     : rv_decode_pkg::ALU_SRL;  // same for srli/srai
			end
			rv_decode_pkg::F3_OR:   alu_f3 = rv_decode_pkg::ALU_OR;
			default:                alu_f3 = rv_decode_pkg::ALU_AND;
		endcase
	end

	////////////////////
	// opcode decode
	////////////////////
	always_comb begin : ctrl_decode
		// rs1 + imm, add, write back alu
		ctrl_nxt.a_sel       = rv_decode_pkg::A_SEL_RS1;
		ctrl_nxt.b_sel       = rv_decode_pkg::B_SEL_IMM;
		ctrl_nxt.alu_op      = rv_decode_pkg::ALU_ADD;
		ctrl_nxt.mem_read    = 1'b0;
		ctrl_nxt.mem_write   = 1'b0;
		ctrl_nxt.mem_len     = rv_decode_pkg::L32;
		ctrl_nxt.load_signed = 1'b1;
		ctrl_nxt.wb_src      = rv_decode_pkg::WB_ALU;
		ctrl_nxt.reg_we      = 1'b1;
		ctrl_nxt.illegal     = ~canon_i.legal;
		case (canon_i.opcode)
			rv_decode_pkg::OPC_LUI:   ctrl_nxt.a_sel = rv_decode_pkg::A_SEL_ZERO; // 0 + imm
			rv_decode_pkg::OPC_AUIPC: ctrl_nxt.a_sel = rv_decode_pkg::A_SEL_PC;
			rv_decode_pkg::OPC_JAL: begin  // target pc + imm, rd gets pc + 4
				ctrl_nxt.a_sel  = rv_decode_pkg::A_SEL_PC;
				ctrl_nxt.wb_src = rv_decode_pkg::WB_PC4;
			end
			rv_decode_pkg::OPC_JALR:  ctrl_nxt.wb_src = rv_decode_pkg::WB_PC4;
			rv_decode_pkg::OPC_BRANCH: begin
				ctrl_nxt.a_sel  = rv_decode_pkg::A_SEL_PC;  // alu builds the target
				ctrl_nxt.reg_we = 1'b0;
			end
			rv_decode_pkg::OPC_LOAD: begin
				ctrl_nxt.mem_read = 1'b1;
				ctrl_nxt.wb_src   = rv_decode_pkg::WB_LOAD;
				case (canon_i.funct3)
					rv_decode_pkg::F3_LB:  ctrl_nxt.mem_len = rv_decode_pkg::L8;
					rv_decode_pkg::F3_LH:  ctrl_nxt.mem_len = rv_decode_pkg::L16;
					rv_decode_pkg::F3_LBU: begin
						ctrl_nxt.mem_len     = rv_decode_pkg::L8;
						ctrl_nxt.load_signed = 1'b0;
					end
					rv_decode_pkg::F3_LHU: begin
						ctrl_nxt.mem_len     = rv_decode_pkg::L16;
						ctrl_nxt.load_signed = 1'b0;
					end
					default: ctrl_nxt.mem_len = rv_decode_pkg::L32;  // lw
				endcase
			end
			rv_decode_pkg::OPC_STORE: begin
				ctrl_nxt.mem_write = 1'b1;
				ctrl_nxt.reg_we    = 1'b0;
				case (canon_i.funct3)
					rv_decode_pkg::F3_SB: ctrl_nxt.mem_len = rv_decode_pkg::L8;
					rv_decode_pkg::F3_SH: ctrl_nxt.mem_len = rv_decode_pkg::L16;
					default:              ctrl_nxt.mem_len = rv_decode_pkg::L32;  // sw
				endcase
			end
			rv_decode_pkg::OPC_OP_IMM: ctrl_nxt.alu_op = alu_f3;
			rv_decode_pkg::OPC_OP: begin
				ctrl_nxt.b_sel  = rv_decode_pkg::B_SEL_RS2;
				ctrl_nxt.alu_op = alu_f3;
			end
			default: ctrl_nxt.illegal = 1'b1;  // outside the known set
		endcase
		// illegal words must not touch memory or the register file
		if (ctrl_nxt.illegal) begin
			ctrl_nxt.mem_read  = 1'b0;
			ctrl_nxt.mem_write = 1'b0;
			ctrl_nxt.reg_we    = 1'b0;
		end
	end

	////////////////////
	// bundle register
	////////////////////
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q <= 1'b0;
			ctrl_q  <= '0;  // strobes and we low
		end else begin
			valid_q <= canon_valid_i;
			if (canon_valid_i)
				ctrl_q <= ctrl_nxt;
		end
	end

	assign ctrl_o       = ctrl_q;
	assign ctrl_valid_o = valid_q;

	a_mem_excl : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ctrl_valid_o |-> !(ctrl_o.mem_read && ctrl_o.mem_write))
		else $error("mem_read and mem_write both set");

endmodule

`default_nettype wire

/* source/rv_decoder_top.sv */
/*
 * Registered RISC-V decoder.
 * Expander, delay pipe and control generator in a row; a control bundle
 * leaves DECODE_LATENCY cycles after each accepted instruction word.
 */
`default_nettype none

module rv_decoder_top (
	input  wire logic                          clk_i,
	input  wire logic                          arst_n_i,
	input  wire logic [rv_decode_pkg::INST_W-1:0] inst_i,
	input  wire logic                          inst_valid_i,
	output rv_decode_pkg::ctrl_bundle_t        ctrl_o,
	output logic                               ctrl_valid_o
);

	rv_decode_pkg::canon_inst_t exp_canon;   // expander out
	logic                       exp_valid;
	rv_decode_pkg::canon_inst_t pipe_canon;  // pipe out
	logic                       pipe_valid;

	rvc_expander u_expander (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.inst_i        (inst_i),
		.inst_valid_i  (inst_valid_i),
		.canon_o       (exp_canon),
		.canon_valid_o (exp_valid)
	);

	decode_pipe #(
		.STAGES (rv_decode_pkg::PIPE_STAGES)
	) u_pipe (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.canon_i       (exp_canon),
		.canon_valid_i (exp_valid),
		.canon_o       (pipe_canon),
		.canon_valid_o (pipe_valid)
	);

	ctrl_generator u_ctrl (
		.clk_i         (clk_i),
		.arst_n_i      (arst_n_i),
		.canon_i       (pipe_canon),
		.canon_valid_i (pipe_valid),
		.ctrl_o        (ctrl_o),
		.ctrl_valid_o  (ctrl_valid_o)
	);

endmodule

`default_nettype wire

/* tests/tb_ref_model.svh */
/*
 * Reference rules for the decoder testbench.
 * expand_ref maps a 32 bit or RVC word onto canonical opcode fields, and
 * expected_ctrl turns a word into the control bundle the DUT should emit.
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// canonical fields of one word, rvc mapped onto its rv32 form
function automatic void expand_ref(input logic [31:0] w, output logic [4:0] opc,
		output logic [2:0] f3, output logic alt, output logic legal);
	opc   = rv_decode_pkg::OPC_OP_IMM;  // addi unless a rule says otherwise
	f3    = 3'b000;
	alt   = 1'b0;
	legal = 1'b1;
	if (w[1:0] == 2'b11) begin
		opc   = w[6:2];
		f3    = w[14:12];
		alt   = w[30];
		legal = (opc == rv_decode_pkg::OPC_LUI)    || (opc == rv_decode_pkg::OPC_AUIPC) ||
		        (opc == rv_decode_pkg::OPC_JAL)    || (opc == rv_decode_pkg::OPC_JALR)  ||
		        (opc == rv_decode_pkg::OPC_BRANCH) || (opc == rv_decode_pkg::OPC_LOAD)  ||
		        (opc == rv_decode_pkg::OPC_STORE)  || (opc == rv_decode_pkg::OPC_OP_IMM) ||
		        (opc == rv_decode_pkg::OPC_OP);
	end else if (w[1:0] == 2'b00) begin
		if (w[15:13] == 3'b010) begin       // c.lw
			opc = rv_decode_pkg::OPC_LOAD;
			f3  = 3'b010;
		end else if (w[15:13] == 3'b110) begin  // c.sw
			opc = rv_decode_pkg::OPC_STORE;
			f3  = 3'b010;
		end else if (w[15:13] != 3'b000)
			legal = 1'b0;
	end else if (w[1:0] == 2'b01) begin
		case (w[15:13])
			3'b001, 3'b101: opc = rv_decode_pkg::OPC_JAL;
			3'b011: opc = (w[11:7] == 5'd2) ? rv_decode_pkg::OPC_OP_IMM
			                                : rv_decode_pkg::OPC_LUI;
			3'b110, 3'b111: begin  // beqz, bnez
				opc = rv_decode_pkg::OPC_BRANCH;
				f3  = {2'b00, w[13]};
			end
			3'b100: begin
				if (w[11:10] == 2'b11) begin
					opc = rv_decode_pkg::OPC_OP;
					f3  = (w[6:5] == 2'b00) ? 3'b000 :
					      (w[6:5] == 2'b01) ? 3'b100 :
					      (w[6:5] == 2'b10) ? 3'b110 : 3'b111;
					alt = (w[6:5] == 2'b00);  // c.sub
				end else begin
					f3  = (w[11:10] == 2'b10) ? 3'b111 : 3'b101;
					alt = (w[11:10] == 2'b01);  // c.srai
				end
			end
			default: ;  // c.addi, c.li
		endcase
	end else begin
		case (w[15:13])
			3'b000: f3 = 3'b001;  // c.slli
			3'b010: begin
				opc = rv_decode_pkg::OPC_LOAD;
				f3  = 3'b010;
			end
			3'b100: begin
				if (w[11:7] == 5'd0)
					legal = 1'b0;  // ebreak lands here
				else
					opc = (w[6:2] == 5'd0) ? rv_decode_pkg::OPC_JALR : rv_decode_pkg::OPC_OP;
			end
			3'b110: begin
				opc = rv_decode_pkg::OPC_STORE;
				f3  = 3'b010;
			end
			default: legal = 1'b0;
		endcase
	end
endfunction

// alu op for the OP / OP_IMM groups
function automatic rv_decode_pkg::alu_op_e alu_ref(input logic [2:0] f3, input logic alt,
		input logic reg_form);
	case (f3)
		3'b000:  return (reg_form && alt) ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
		3'b001:  return rv_decode_pkg::ALU_SLL;
		3'b010:  return rv_decode_pkg::ALU_SLT;
		3'b011:  return rv_decode_pkg::ALU_SLTU;
		3'b100:  return rv_decode_pkg::ALU_XOR;
		3'b101:  return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
		3'b110:  return rv_decode_pkg::ALU_OR;
		default: return rv_decode_pkg::ALU_AND;
	endcase
endfunction

function automatic rv_decode_pkg::ctrl_bundle_t expected_ctrl(input logic [31:0] w);
	rv_decode_pkg::ctrl_bundle_t e;
	logic [4:0] opc;
	logic [2:0] f3;
	logic       alt;
	logic       legal;
	expand_ref(w, opc, f3, alt, legal);
	e.illegal   = !legal;
	e.a_sel     = (opc == rv_decode_pkg::OPC_LUI) ? rv_decode_pkg::A_SEL_ZERO :
	              (opc == rv_decode_pkg::OPC_AUIPC || opc == rv_decode_pkg::OPC_JAL ||
	               opc == rv_decode_pkg::OPC_BRANCH) ? rv_decode_pkg::A_SEL_PC
	                                                 : rv_decode_pkg::A_SEL_RS1;
	e.b_sel     = (opc == rv_decode_pkg::OPC_OP) ? rv_decode_pkg::B_SEL_RS2
	                                             : rv_decode_pkg::B_SEL_IMM;
	e.alu_op    = (opc == rv_decode_pkg::OPC_OP || opc == rv_decode_pkg::OPC_OP_IMM) ?
	              alu_ref(f3, alt, opc == rv_decode_pkg::OPC_OP) : rv_decode_pkg::ALU_ADD;
	e.mem_read  = (opc == rv_decode_pkg::OPC_LOAD);
	e.mem_write = (opc == rv_decode_pkg::OPC_STORE);
	e.mem_len     = rv_decode_pkg::L32;
	e.load_signed = 1'b1;
	if (e.mem_read || e.mem_write) begin
		if (f3 == 3'b000 || (e.mem_read && f3 == 3'b100))
			e.mem_len = rv_decode_pkg::L8;
		else if (f3 == 3'b001 || (e.mem_read && f3 == 3'b101))
			e.mem_len = rv_decode_pkg::L16;
		e.load_signed = !(e.mem_read && (f3 == 3'b100 || f3 == 3'b101));  // lbu, lhu
	end
	e.wb_src    = (opc == rv_decode_pkg::OPC_JAL || opc == rv_decode_pkg::OPC_JALR) ?
	              rv_decode_pkg::WB_PC4 :
	              e.mem_read ? rv_decode_pkg::WB_LOAD : rv_decode_pkg::WB_ALU;
	e.reg_we    = !(opc == rv_decode_pkg::OPC_STORE || opc == rv_decode_pkg::OPC_BRANCH);
	if (e.illegal) begin
		e.mem_read  = 1'b0;
		e.mem_write = 1'b0;
		e.reg_we    = 1'b0;
	end
	return e;
endfunction

`endif

/* tests/tb_rv_decoder.sv */
/*
 * Testbench of the registered RISC-V decoder.
 * Random words from a template table go in, expected bundles wait in a
 * queue, and concurrent assertions compare fields and check the latency.
 */
`default_nettype none

module tb_rv_decoder;
	timeunit 1ns;
	timeprecision 100ps;

	`include "tb_ref_model.svh"

	localparam int N_CYCLES = 400;  // stimulus cycles
	localparam int LAT      = rv_decode_pkg::DECODE_LATENCY;
	localparam int TIMEOUT  = N_CYCLES + LAT + 2 + 20;
	localparam int N_TMPL   = 18;

	// fixed opcode bits plus a mask of the fields filled at random
	localparam logic [31:0] TMPL_BASE [N_TMPL] = '{
		32'h33, 32'h13, 32'h03, 32'h23, 32'h63, 32'h37, 32'h17, 32'h6F, 32'h67,
		32'h03,                                   // any opcode
		32'h0000, 32'h0001, 32'h8001, 32'h0002,   // rvc quadrants
		32'h8002, 32'h8002, 32'h8002, 32'h6101};  // q2 jr/mv/ebreak, addi16sp
	localparam logic [31:0] TMPL_MASK [N_TMPL] = '{
		32'h41FF_FF80, 32'hFFFF_FF80, 32'hFFFF_FF80, 32'hFFFF_FF80, 32'hFFFF_FF80,
		32'hFFFF_FF80, 32'hFFFF_FF80, 32'hFFFF_FF80, 32'hFFFF_FF80,
		32'hFFFF_FFFC,
		32'hFFFC, 32'hFFFC, 32'h1FFC, 32'hFFFC,
		32'h1FFC, 32'h107C, 32'h1F80, 32'h107C};

	logic                        clk_i = 1'b0;
	logic                        arst_n_i;
	logic [31:0]                 inst_i;
	logic                        inst_valid_i;
	rv_decode_pkg::ctrl_bundle_t ctrl_o;
	logic                        ctrl_valid_o;

	logic [15:0]                 lfsr_q = 16'd22;
	rv_decode_pkg::ctrl_bundle_t exp_q [$];   // expected, oldest first
	rv_decode_pkg::ctrl_bundle_t exp_head;
	logic                        head_ok = 1'b0;
	logic                        out_pending = 1'b0;  // output due at next edge
	int                          mismatch_cnt = 0;
	int                          protocol_cnt = 0;
	int                          sent_cnt = 0;
	int                          cycle_cnt = 0;

	rv_decoder_top UUT (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.ctrl_o       (ctrl_o),
		.ctrl_valid_o (ctrl_valid_o)
	);

	initial begin
		forever #2 clk_i = ~clk_i;
	end

	// fibonacci, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        nb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			nb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
			lfsr_q = {lfsr_q[14:0], nb};
			r      = {r[30:0], nb};
		end
		return r;
	endfunction

	function automatic void note_mismatch(input string field, input int got, input int exp);
		mismatch_cnt++;
		$display("MISMATCH t=%0t %s: got %0d expected %0d", $time, field, got, exp);
	endfunction

	function automatic void note_error(input string msg);
		protocol_cnt++;
		$display("ERROR t=%0t: %s", $time, msg);
	endfunction

	// drop the entry checked at the last edge, expose the next one
	function automatic void advance_queue();
		if (out_pending && exp_q.size() > 0)
			void'(exp_q.pop_front());
		head_ok = (exp_q.size() > 0);
		if (head_ok)
			exp_head = exp_q[0];
		out_pending = ctrl_valid_o;
	endfunction

	initial begin : stimulus
		int idx;
		arst_n_i     = 1'b0;
		inst_i       = '0;
		inst_valid_i = 1'b0;
		repeat (2) @(posedge clk_i);
		#0.5 arst_n_i = 1'b1;
		for (int c = 0; c < N_CYCLES; c++) begin
			@(posedge clk_i);
			#0.5;
			idx          = rand_bits(5) % N_TMPL;
			inst_i       = TMPL_BASE[idx] | (rand_bits(32) & TMPL_MASK[idx]);
			inst_valid_i = (c >= 3) && (rand_bits(2) != 0);  // idle first, then bursty
			if (inst_valid_i) begin
				exp_q.push_back(expected_ctrl(inst_i));
				sent_cnt++;
			end
			advance_queue();
		end
		@(posedge clk_i);
		#0.5 inst_valid_i = 1'b0;
		advance_queue();
		while (exp_q.size() > 0 || out_pending) begin  // drain
			@(posedge clk_i);
			#0.5 advance_queue();
		end
		$display("done: %0d words sent, %0d mismatches, %0d other errors",
			sent_cnt, mismatch_cnt, protocol_cnt);
		if (mismatch_cnt + protocol_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	always @(posedge clk_i) begin : watchdog
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT) begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT);
			$display("done: %0d words sent, %0d mismatches, %0d other errors",
				sent_cnt, mismatch_cnt, protocol_cnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////
	// latency, order
	////////////////////
	a_lat_fwd : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		inst_valid_i |-> ##LAT ctrl_valid_o)
		else note_error("input strobe gave no output strobe at the fixed latency");
	a_lat_back : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ctrl_valid_o |-> $past(inst_valid_i, LAT))
		else note_error("output strobe without an input strobe at the fixed latency");
	a_head : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ctrl_valid_o |-> head_ok)
		else note_error("output strobe arrived while no expected bundle was queued");

	////////////////////
	// bundle fields
	////////////////////
	// strobes, we and illegal always checked
	a_illegal : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok) |-> ctrl_o.illegal == exp_head.illegal)
		else note_mismatch("illegal", int'($sampled(ctrl_o.illegal)),
			int'(exp_head.illegal));
	a_mem_read : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok) |-> ctrl_o.mem_read == exp_head.mem_read)
		else note_mismatch("mem_read", int'($sampled(ctrl_o.mem_read)),
			int'(exp_head.mem_read));
	a_mem_write : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok) |-> ctrl_o.mem_write == exp_head.mem_write)
		else note_mismatch("mem_write", int'($sampled(ctrl_o.mem_write)),
			int'(exp_head.mem_write));
	a_reg_we : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok) |-> ctrl_o.reg_we == exp_head.reg_we)
		else note_mismatch("reg_we", int'($sampled(ctrl_o.reg_we)),
			int'(exp_head.reg_we));
	// the rest only means something for legal words
	a_a_sel : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |-> ctrl_o.a_sel == exp_head.a_sel)
		else note_mismatch("a_sel", int'($sampled(ctrl_o.a_sel)),
			int'(exp_head.a_sel));
	a_b_sel : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |-> ctrl_o.b_sel == exp_head.b_sel)
		else note_mismatch("b_sel", int'($sampled(ctrl_o.b_sel)),
			int'(exp_head.b_sel));
	a_alu_op : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |-> ctrl_o.alu_op == exp_head.alu_op)
		else note_mismatch("alu_op", int'($sampled(ctrl_o.alu_op)),
			int'(exp_head.alu_op));
	a_mem_len : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |-> ctrl_o.mem_len == exp_head.mem_len)
		else note_mismatch("mem_len", int'($sampled(ctrl_o.mem_len)),
			int'(exp_head.mem_len));
	a_signed : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |->
		ctrl_o.load_signed == exp_head.load_signed)
		else note_mismatch("load_signed", int'($sampled(ctrl_o.load_signed)),
			int'(exp_head.load_signed));
	a_wb_src : assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ctrl_valid_o && head_ok && !exp_head.illegal) |-> ctrl_o.wb_src == exp_head.wb_src)
		else note_mismatch("wb_src", int'($sampled(ctrl_o.wb_src)),
			int'(exp_head.wb_src));

endmodule

`default_nettype wire

/* rv_decoder_top.f */
+incdir+tests
source/rv_decode_pkg.sv
source/rvc_expander.sv
source/decode_pipe.sv
source/ctrl_generator.sv
source/rv_decoder_top.sv
tests/tb_rv_decoder.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decoder testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_decoder_top.f \
	--top-module tb_rv_decoder -Mdir obj_dir -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
